// File: src/box_config.svh
`ifndef BOX_CONFIG_SVH
`define BOX_CONFIG_SVH

// frame geometry
// pixels per row
`define BOX_COLS 16
// rows per frame
`define BOX_ROWS 4

// horizontal window width in pixels
`define BOX_WIN 12

// pixel and sum word widths
`define BOX_PIX_W 8
// 12 full-scale pixels fit in 12 bits
`define BOX_SUM_W 12

// settle cycles spent in start before the first row
`define BOX_START_WAIT 3

`endif

// File: src/box_pkg.sv
`include "box_config.svh"

package box_pkg;

  // address field widths
  localparam int COL_W = $clog2(`BOX_COLS);
  localparam int ROW_W = $clog2(`BOX_ROWS);
  // row counters must also hold the full row count
  localparam int ROW_CW = $clog2(`BOX_ROWS + 1);
  // bank bit on top of row and column
  localparam int ADDR_W = 1 + ROW_W + COL_W;

  typedef logic [`BOX_PIX_W-1:0] pix_t;
  typedef logic [`BOX_SUM_W-1:0] sum_t;

  // bank, then row, then column
  typedef struct packed {
    logic             bank;
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
  } addr_t;

  // one memory access, shared by loader, reader, arbiter and ram
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    pix_t  data;
  } mem_req_t;

  // what to do with a pixel when its read data comes back
  typedef struct packed {
    logic strobe;
    logic ld;
    logic add;
    logic cum;
  } rd_tag_t;

  // row controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_START_ROW,
    ST_SUM_FILL,
    ST_CUM_OUT,
    ST_FINISH_ALL,
    ST_DONE
  } ctrl_state_e;

endpackage

// File: src/frame_mem.sv
`timescale 1ns/1ps

module frame_mem
  import box_pkg::*;
(
  input  logic     clk,
  input  mem_req_t i_req,
  output pix_t     o_rdata
);

  // two banks, each one whole frame
  localparam int DEPTH = 2 ** ADDR_W;

  // pixel storage
  pix_t mem [DEPTH];

  // read data register
  pix_t rdata_q;

  // single port
  // a write takes the cycle, no read data
  always_ff @(posedge clk) begin
    if (i_req.req && i_req.we) begin
      mem[i_req.addr] <= i_req.data;
    end
  end

  // one cycle read latency
  // holds last value when not reading
  always_ff @(posedge clk) begin
    if (i_req.req && !i_req.we) begin
      rdata_q <= mem[i_req.addr];
    end
  end

  // valid qualification comes from the arbiter
  assign o_rdata = rdata_q;

endmodule

// File: src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
  import box_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  mem_req_t i_ld_req,
  input  mem_req_t i_rd_req,
  output mem_req_t o_mem_req,
  output logic     o_rd_stall,
  output logic     o_rd_valid
);

  // reader got the port this cycle
  logic rd_grant;
  // marks the cycle read data comes back
  logic rd_valid_q;

  // loader always first
  // input pixels are never refused
  always_comb begin
    if (i_ld_req.req) begin
      o_mem_req = i_ld_req;
    end else begin
      o_mem_req = i_rd_req;
    end
  end

  // reader loses only against a live loader request
  assign o_rd_stall = i_rd_req.req && i_ld_req.req;

  // reader gets the port only when the loader is idle
  assign rd_grant = i_rd_req.req && !i_ld_req.req;

  // delayed grant
  // lines up with ram read latency
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_grant;
    end
  end

  assign o_rd_valid = rd_valid_q;

  // a blocked read must be retried as-is, else a pixel is lost
  a_rd_held : assert property (
    @(posedge clk) disable iff (!rst_n)
    (i_rd_req.req && o_rd_stall) |=> (i_rd_req == $past(i_rd_req))
  );

endmodule

// File: src/pixel_loader.sv
`timescale 1ns/1ps
`include "box_config.svh"

module pixel_loader
  import box_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     i_pix_valid,
  input  pix_t     i_pix_data,
  input  logic     i_frame_end,
  output mem_req_t o_req,
  output logic     o_frame_ready,
  output logic     o_ready_bank
);

  // write bank, flips each frame
  logic              bank_q;
  // wide enough to reach BOX_ROWS after the last pixel
  logic [ROW_CW-1:0] row_q;
  logic [COL_W-1:0]  col_q;

  // write goes out in the same cycle as the pixel
  always_comb begin
    o_req.req       = i_pix_valid;
    o_req.we        = 1'b1;
    o_req.addr.bank = bank_q;
    o_req.addr.row  = row_q[ROW_W-1:0];
    o_req.addr.col  = col_q;
    o_req.data      = i_pix_data;
  end

  // row-major position counters
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bank_q <= 1'b0;
      row_q  <= '0;
      col_q  <= '0;
    end else if (i_frame_end) begin
      // frame end wins, a coinciding pixel was written above
      bank_q <= ~bank_q;
      row_q  <= '0;
      col_q  <= '0;
    end else if (i_pix_valid) begin
      if (int'(col_q) == `BOX_COLS - 1) begin
        col_q <= '0;
        row_q <= row_q + 1'b1;
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // hand the filled bank to the reader side
  assign o_frame_ready = i_frame_end;
  assign o_ready_bank  = bank_q;

  // frame end only after a full frame, counting a last pixel in the same cycle
  a_full_frame : assert property (
    @(posedge clk) disable iff (!rst_n)
    i_frame_end |-> (i_pix_valid ?
      (int'(row_q) == `BOX_ROWS - 1 && int'(col_q) == `BOX_COLS - 1) :
      (int'(row_q) == `BOX_ROWS && col_q == '0))
  );

endmodule

// File: src/row_controller.sv
`timescale 1ns/1ps
`include "box_config.svh"

module row_controller
  import box_pkg::*;
#(
  parameter int COLS = `BOX_COLS
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       i_frame_ready,
  input  logic                       i_stall,
  input  logic                       i_start_gt_wait,
  input  logic [$clog2(COLS+1)-1:0]  i_counter,
  input  logic                       i_row_eq_max,
  output logic                       o_start_en,
  output logic                       o_ld_en,
  output logic                       o_count_en,
  output logic                       o_sum_en,
  output logic                       o_cum_en,
  output logic                       o_out_strobe,
  output logic                       o_progress_done
);

  ctrl_state_e state_q, state_d, prev_q;

  // ungated moore outputs
  logic start_raw, ld_raw, count_raw, sum_raw, cum_raw, strobe_raw, done_raw;

  // state and previous state freeze while the reader is stalled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      prev_q  <= ST_IDLE;
    end else if (!i_stall) begin
      state_q <= state_d;
      prev_q  <= state_q;
    end
  end

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (i_frame_ready) state_d = ST_START;
      end
      ST_START: begin
        if (i_row_eq_max) state_d = ST_FINISH_ALL;
        else if (i_start_gt_wait) state_d = ST_START_ROW;
      end
      ST_START_ROW: begin
        state_d = i_row_eq_max ? ST_FINISH_ALL : ST_SUM_FILL;
      end
      ST_SUM_FILL: begin
        // window filled once column WIN-1 is issued
        if (i_row_eq_max) state_d = ST_FINISH_ALL;
        else if (int'(i_counter) > `BOX_WIN - 2) state_d = ST_CUM_OUT;
      end
      ST_CUM_OUT: begin
        // last column of the row issued
        if (i_row_eq_max) state_d = ST_FINISH_ALL;
        else if (int'(i_counter) > COLS - 2) state_d = ST_START_ROW;
      end
      ST_FINISH_ALL: state_d = ST_DONE;
      ST_DONE: begin
        // back to idle, or straight on when the next frame is already ready
        state_d = i_frame_ready ? ST_START : ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // enables per state
  always_comb begin
    start_raw  = 1'b0;
    ld_raw     = 1'b0;
    count_raw  = 1'b0;
    sum_raw    = 1'b0;
    cum_raw    = 1'b0;
    strobe_raw = 1'b0;
    done_raw   = 1'b0;
    case (state_q)
      ST_START: start_raw = 1'b1;
      ST_START_ROW: begin
        count_raw = 1'b1;
        ld_raw    = 1'b1;
        // closes the window of the row just finished
        strobe_raw = (prev_q == ST_CUM_OUT);
      end
      ST_SUM_FILL: begin
        count_raw = 1'b1;
        sum_raw   = 1'b1;
      end
      ST_CUM_OUT: begin
        count_raw  = 1'b1;
        sum_raw    = 1'b1;
        cum_raw    = 1'b1;
        strobe_raw = 1'b1;
      end
      ST_FINISH_ALL: done_raw = 1'b1;
      default: ;
    endcase
  end

  // nothing moves during a stall
  assign o_start_en      = start_raw & ~i_stall;
  assign o_ld_en         = ld_raw & ~i_stall;
  assign o_count_en      = count_raw & ~i_stall;
  assign o_sum_en        = sum_raw & ~i_stall;
  assign o_cum_en        = cum_raw & ~i_stall;
  assign o_out_strobe    = strobe_raw & ~i_stall;
  assign o_progress_done = done_raw & ~i_stall;

  a_state_legal : assert property (
    @(posedge clk) disable iff (!rst_n)
    state_q inside {ST_IDLE, ST_START, ST_START_ROW, ST_SUM_FILL,
                    ST_CUM_OUT, ST_FINISH_ALL, ST_DONE}
  );

  // a new frame must not land on a bank still being filtered
  a_no_overrun : assert property (
    @(posedge clk) disable iff (!rst_n)
    i_frame_ready |-> (state_q inside {ST_IDLE, ST_DONE})
  );

endmodule

// File: src/row_window_sum.sv
`timescale 1ns/1ps
`include "box_config.svh"

module row_window_sum
  import box_pkg::*;
#(
  parameter int COLS = `BOX_COLS
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      i_start_en,
  input  logic                      i_ld_en,
  input  logic                      i_count_en,
  input  logic                      i_sum_en,
  input  logic                      i_cum_en,
  input  logic                      i_out_strobe,
  input  logic                      i_frame_ready,
  input  logic                      i_bank,
  input  logic                      i_rd_valid,
  input  pix_t                      i_rdata,
  output mem_req_t                  o_req,
  output logic                      o_start_gt_wait,
  output logic [$clog2(COLS+1)-1:0] o_counter,
  output logic                      o_row_eq_max,
  output sum_t                      o_sum,
  output logic                      o_sum_valid
);

  localparam int CNT_W = $clog2(COLS + 1);
  localparam int SET_W = $clog2(`BOX_START_WAIT + 1);

  logic              bank_q;
  logic [SET_W-1:0]  settle_q;
  logic [CNT_W-1:0]  col_q;
  // column addressed this cycle
  // row start is always column 0
  logic [CNT_W-1:0]  col_issue;
  // row addressed this cycle
  logic [ROW_W-1:0]  row_issue;
  // rows started, and rows whose last window went out
  logic [ROW_CW-1:0] rd_row_q;
  logic [ROW_CW-1:0] rows_done_q;
  // closing strobe of the last row already issued
  logic              last_q;
  logic              issue;
  // pending read and its tag, then the tag of the read in flight
  mem_req_t          req_q;
  rd_tag_t           req_tag_q;
  rd_tag_t           fly_tag_q;
  sum_t              sum_q;
  sum_t              leave;
  // newest pixel at index 0
  pix_t              win_sr [`BOX_WIN];
  sum_t              sum_q_out;
  logic              sum_valid_q;

  assign col_issue = i_ld_en ? '0 : col_q;

  // a load reads the row it starts
  // later reads stay one behind the rows started
  assign row_issue = i_ld_en ? rd_row_q[ROW_W-1:0] : rd_row_q[ROW_W-1:0] - 1'b1;

  // after the last row only the closing strobe still needs a slot
  assign issue = i_count_en && (i_ld_en || !last_q);

  // control state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bank_q      <= 1'b0;
      settle_q    <= '0;
      col_q       <= '0;
      rd_row_q    <= '0;
      rows_done_q <= '0;
      last_q      <= 1'b0;
      req_q.req   <= 1'b0;
      sum_valid_q <= 1'b0;
    end else begin
      if (i_frame_ready) begin
        // latch the bank that was just filled
        bank_q      <= i_bank;
        settle_q    <= '0;
        rd_row_q    <= '0;
        rows_done_q <= '0;
        last_q      <= 1'b0;
      end else begin
        if (i_start_en && int'(settle_q) < `BOX_START_WAIT) begin
          settle_q <= settle_q + 1'b1;
        end
        if (i_ld_en && int'(rd_row_q) < `BOX_ROWS) begin
          rd_row_q <= rd_row_q + 1'b1;
        end
        // load after the last row only closes its final window
        if (i_ld_en && int'(rd_row_q) == `BOX_ROWS) begin
          last_q <= 1'b1;
        end
        // end-of-row window leaves the block
        if (i_rd_valid && fly_tag_q.strobe && fly_tag_q.ld) begin
          rows_done_q <= rows_done_q + 1'b1;
        end
      end
      if (i_count_en) begin
        col_q <= col_issue + 1'b1;
        // count_en only comes unstalled, so a pending read was granted now
        req_q.req <= issue;
      end
      sum_valid_q <= i_rd_valid && fly_tag_q.strobe;
    end
  end

  // request payload and tags
  always_ff @(posedge clk) begin
    if (i_count_en) begin
      req_q.we        <= 1'b0;
      req_q.addr.bank <= bank_q;
      req_q.addr.row  <= row_issue;
      req_q.addr.col  <= col_issue[COL_W-1:0];
      req_q.data      <= '0;
      req_tag_q       <= '{strobe: i_out_strobe, ld: i_ld_en, add: i_sum_en, cum: i_cum_en};
      fly_tag_q       <= req_tag_q;
    end
  end

  // pixel leaving the window
  assign leave = fly_tag_q.cum ? sum_t'(win_sr[`BOX_WIN-1]) : '0;

  // running sum, in read order
  always_ff @(posedge clk) begin
    if (i_rd_valid) begin
      // strobe shows the window before this pixel joins
      if (fly_tag_q.strobe) begin
        sum_q_out <= sum_q;
      end
      if (fly_tag_q.ld) begin
        sum_q <= sum_t'(i_rdata);
      end else if (fly_tag_q.add) begin
        sum_q <= sum_q + sum_t'(i_rdata) - leave;
      end
      win_sr[0] <= i_rdata;
      for (int i = 1; i < `BOX_WIN; i++) begin
        win_sr[i] <= win_sr[i-1];
      end
    end
  end

  assign o_req           = req_q;
  assign o_start_gt_wait = int'(settle_q) >= `BOX_START_WAIT - 1;
  assign o_counter       = col_q;
  // true only once the final window is out
  assign o_row_eq_max    = int'(rows_done_q) == `BOX_ROWS;
  assign o_sum           = sum_q_out;
  assign o_sum_valid     = sum_valid_q;

endmodule

// File: src/box_filter_top.sv
`timescale 1ns/1ps
`include "box_config.svh"

module box_filter_top
  import box_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic i_pix_valid,
  input  pix_t i_pix_data,
  input  logic i_frame_end,
  output sum_t o_sum,
  output logic o_sum_valid,
  output logic o_frame_done
);

  localparam int CNT_W = $clog2(`BOX_COLS + 1);

  // memory side
  mem_req_t ld_req;
  mem_req_t rd_req;
  mem_req_t mem_req;
  pix_t     rdata;
  logic     rd_stall;
  logic     rd_valid;

  // frame hand-off
  logic frame_ready;
  logic ready_bank;

  // controller enables
  logic start_en, ld_en, count_en, sum_en, cum_en, out_strobe;

  // status back to the controller
  logic             start_gt_wait;
  logic [CNT_W-1:0] counter;
  logic             row_eq_max;

  // stream into the write bank
  pixel_loader u_pixel_loader (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_pix_valid   (i_pix_valid),
    .i_pix_data    (i_pix_data),
    .i_frame_end   (i_frame_end),
    .o_req         (ld_req),
    .o_frame_ready (frame_ready),
    .o_ready_bank  (ready_bank)
  );

  // reader and window sum
  row_window_sum u_row_window_sum (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_start_en      (start_en),
    .i_ld_en         (ld_en),
    .i_count_en      (count_en),
    .i_sum_en        (sum_en),
    .i_cum_en        (cum_en),
    .i_out_strobe    (out_strobe),
    .i_frame_ready   (frame_ready),
    .i_bank          (ready_bank),
    .i_rd_valid      (rd_valid),
    .i_rdata         (rdata),
    .o_req           (rd_req),
    .o_start_gt_wait (start_gt_wait),
    .o_counter       (counter),
    .o_row_eq_max    (row_eq_max),
    .o_sum           (o_sum),
    .o_sum_valid     (o_sum_valid)
  );

  // loader first
  mem_arbiter u_mem_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_ld_req   (ld_req),
    .i_rd_req   (rd_req),
    .o_mem_req  (mem_req),
    .o_rd_stall (rd_stall),
    .o_rd_valid (rd_valid)
  );

  frame_mem u_frame_mem (
    .clk     (clk),
    .i_req   (mem_req),
    .o_rdata (rdata)
  );

  row_controller u_row_controller (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_frame_ready   (frame_ready),
    .i_stall         (rd_stall),
    .i_start_gt_wait (start_gt_wait),
    .i_counter       (counter),
    .i_row_eq_max    (row_eq_max),
    .o_start_en      (start_en),
    .o_ld_en         (ld_en),
    .o_count_en      (count_en),
    .o_sum_en        (sum_en),
    .o_cum_en        (cum_en),
    .o_out_strobe    (out_strobe),
    .o_progress_done (o_frame_done)
  );

endmodule

// File: bench/tb_box_filter.sv
`timescale 1ns/1ps
`include "box_config.svh"

module tb_box_filter
  import box_pkg::*;
();

  localparam int NUM_FRAMES     = 2;
  localparam int PIX_PER_FRAME  = `BOX_COLS * `BOX_ROWS;
  // windows per row times rows
  localparam int OUTS_PER_FRAME = `BOX_ROWS * (`BOX_COLS - `BOX_WIN + 1);
  localparam int WAIT_LIMIT     = 1000;

  logic clk;
  logic rst_n;
  logic i_pix_valid;
  pix_t i_pix_data;
  logic i_frame_end;
  sum_t o_sum;
  logic o_sum_valid;
  logic o_frame_done;

  // reference model storage
  pix_t frames [NUM_FRAMES][PIX_PER_FRAME];
  sum_t exp_q [$];
  sum_t exp_head;
  logic exp_avail;

  // monitor state
  int   cycle_cnt = 0;
  int   out_in_frame = 0;
  int   out_total = 0;
  int   done_cnt = 0;
  logic frame_seen;

  // error tallies
  int reset_errs = 0;
  int sum_errs = 0;
  int count_errs = 0;
  int done_errs = 0;
  int timeout_errs = 0;

  logic [15:0] lfsr_state = 16'd6392;

  box_filter_top u_box_filter_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_pix_valid  (i_pix_valid),
    .i_pix_data   (i_pix_data),
    .i_frame_end  (i_frame_end),
    .o_sum        (o_sum),
    .o_sum_valid  (o_sum_valid),
    .o_frame_done (o_frame_done)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_bit());
    end
    return v;
  endfunction

  // random frames, then every horizontal window sum in row, column order
  task automatic build_frames();
    int acc;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      for (int p = 0; p < PIX_PER_FRAME; p++) begin
        frames[f][p] = pix_t'(rand_bits(`BOX_PIX_W));
      end
    end
    for (int f = 0; f < NUM_FRAMES; f++) begin
      for (int r = 0; r < `BOX_ROWS; r++) begin
        for (int c = 0; c <= `BOX_COLS - `BOX_WIN; c++) begin
          acc = 0;
          for (int k = 0; k < `BOX_WIN; k++) begin
            acc += int'(frames[f][r * `BOX_COLS + c + k]);
          end
          exp_q.push_back(sum_t'(acc));
        end
      end
    end
  endtask

  // one frame of pixels, optional random idle gaps
  task automatic stream_frame(input int f, input bit gaps, input bit end_on_last);
    int gap;
    for (int p = 0; p < PIX_PER_FRAME; p++) begin
      @(posedge clk);
      i_pix_valid <= 1'b1;
      i_pix_data  <= frames[f][p];
      // frame end may ride on the last pixel
      i_frame_end <= end_on_last && (p == PIX_PER_FRAME - 1);
      if (end_on_last && p == PIX_PER_FRAME - 1) begin
        frame_seen <= 1'b1;
      end
      if (gaps) begin
        gap = rand_bits(2);
        repeat (gap) begin
          @(posedge clk);
          i_pix_valid <= 1'b0;
          i_frame_end <= 1'b0;
        end
      end
    end
    @(posedge clk);
    i_pix_valid <= 1'b0;
    i_frame_end <= 1'b0;
  endtask

  task automatic pulse_frame_end();
    @(posedge clk);
    i_frame_end <= 1'b1;
    frame_seen  <= 1'b1;
    @(posedge clk);
    i_frame_end <= 1'b0;
  endtask

  task automatic wait_frames_done(input int target, input int limit);
    int n;
    n = 0;
    while (done_cnt < target && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (done_cnt < target) begin
      timeout_errs++;
      $display("timeout: frame %0d did not finish within %0d cycles", target - 1, limit);
    end
  endtask

  // tracks outputs and keeps the queue head in step
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (o_sum_valid === 1'b1) begin
      if (exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
      out_in_frame <= out_in_frame + 1;
      out_total    <= out_total + 1;
    end
    if (o_frame_done === 1'b1) begin
      out_in_frame <= 0;
      done_cnt     <= done_cnt + 1;
    end
    if (exp_q.size() > 0) begin
      exp_head  <= exp_q[0];
      exp_avail <= 1'b1;
    end else begin
      exp_avail <= 1'b0;
    end
  end

  // quiet through reset until the first frame end
  a_quiet_start : assert property (
    @(posedge clk) (cycle_cnt > 0 && !frame_seen) |-> (!o_sum_valid && !o_frame_done)
  ) else begin
    reset_errs++;
    $display("output strobe or frame done seen before the first frame end");
  end

  a_sum_expected : assert property (@(posedge clk) o_sum_valid |-> exp_avail)
  else begin
    sum_errs++;
    $display("window sum strobed with no expected sum left");
  end

  a_sum_value : assert property (@(posedge clk) o_sum_valid |-> (o_sum == exp_head))
  else begin
    sum_errs++;
    $display("[FAIL] window_sum: expected %0d, actual %0d",
             $sampled(exp_head), $sampled(o_sum));
  end

  // more outputs than a frame holds means a repeat or a missing frame done
  a_no_extra : assert property (
    @(posedge clk) o_sum_valid |-> (out_in_frame < OUTS_PER_FRAME)
  ) else begin
    count_errs++;
    $display("[FAIL] outputs_per_frame: expected at most %0d, actual %0d",
             OUTS_PER_FRAME, $sampled(out_in_frame) + 1);
  end

  a_done_count : assert property (
    @(posedge clk) o_frame_done |-> (out_in_frame == OUTS_PER_FRAME)
  ) else begin
    count_errs++;
    $display("[FAIL] outputs_per_frame: expected %0d, actual %0d",
             OUTS_PER_FRAME, $sampled(out_in_frame));
  end

  a_done_pulse : assert property (@(posedge clk) o_frame_done |=> !o_frame_done)
  else begin
    done_errs++;
    $display("o_frame_done stayed high for more than one cycle");
  end

  initial begin
    rst_n       = 1'b0;
    i_pix_valid = 1'b0;
    i_pix_data  = '0;
    i_frame_end = 1'b0;
    frame_seen  = 1'b0;
    build_frames();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);

    // dense first frame, end on the last pixel
    stream_frame(0, 1'b0, 1'b1);
    // second frame competes with the reader of the first
    fork
      stream_frame(1, 1'b1, 1'b0);
      wait_frames_done(1, WAIT_LIMIT);
    join
    pulse_frame_end();
    wait_frames_done(2, WAIT_LIMIT);
    repeat (5) @(posedge clk);

    a_queue_empty : assert (exp_q.size() == 0)
    else begin
      count_errs++;
      $display("[FAIL] leftover_sums: expected 0, actual %0d", exp_q.size());
    end
    a_total : assert (out_total == NUM_FRAMES * OUTS_PER_FRAME)
    else begin
      count_errs++;
      $display("[FAIL] total_outputs: expected %0d, actual %0d",
               NUM_FRAMES * OUTS_PER_FRAME, out_total);
    end
    a_frames : assert (done_cnt == NUM_FRAMES)
    else begin
      done_errs++;
      $display("[FAIL] frame_done_count: expected %0d, actual %0d", NUM_FRAMES, done_cnt);
    end

    $display("errors: reset %0d, sums %0d, counts %0d, frame_done %0d, timeouts %0d",
             reset_errs, sum_errs, count_errs, done_errs, timeout_errs);
    if (reset_errs + sum_errs + count_errs + done_errs + timeout_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+src
src/box_pkg.sv
src/frame_mem.sv
src/mem_arbiter.sv
src/pixel_loader.sv
src/row_controller.sv
src/row_window_sum.sv
src/box_filter_top.sv
bench/tb_box_filter.sv

// File: Bender.yml
package:
  name: box_filter

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/box_pkg.sv
      - src/frame_mem.sv
      - src/mem_arbiter.sv
      - src/pixel_loader.sv
      - src/row_controller.sv
      - src/row_window_sum.sv
      - src/box_filter_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/tb_box_filter.sv
